/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*, cpu_pipe_pkg::*; (
    input  wire [31:0]   a,
    input  wire [31:0]   b,
    input  wire alu_op_e op,
    input  wire [2:0]    funct3,
    output logic [31:0]  result,
    output logic         taken
);

    logic lt;
    logic ltu;

    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << b[4:0];
            ALU_SLT:    result = {31'b0, lt};
            ALU_SLTU:   result = {31'b0, ltu};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = $signed(a) >>> b[4:0];
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    // Branch comparator, only used when the instruction is a branch
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = a == b;
            F3_BNE:  taken = a != b;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import rv_isa_pkg::*, cpu_pipe_pkg::*; #(
    parameter logic [31:0] RESET_PC   = 32'h0,
    parameter int          IMEM_WORDS = 256,
    parameter int          DMEM_WORDS = 256,
    parameter logic [31:0] HOST_ADDR  = 32'h8000_0000
) (
    input  wire             clk,
    input  wire             rst,
    input  wire imem_load_t imem_load,
    output host_t           host
);

    localparam int IAW = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] fetch_pc;
    logic [31:0] pc_fd;
    inst_u       inst_fd;
    logic        fd_valid;
    ctrl_t       ctrl_fd;
    logic [31:0] imm_fd;
    logic [31:0] rd1;
    logic [31:0] rd2;

    xm_stage_t   xm;
    logic        fwd_a;
    logic        fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        taken;
    logic        redirect;
    logic [31:0] target;

    w_stage_t    w;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        rf_we;

    // pc holds the next fetch address, a redirect overrides it
    assign fetch_pc = redirect ? target : pc;

    always_ff @(posedge clk) begin
        if (rst && imem_load.valid) begin
            imem[imem_load.addr[IAW-1:0]] <= imem_load.data;
        end
        inst_fd <= imem[fetch_pc[IAW+1:2]];
        pc_fd   <= fetch_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            fd_valid <= 1'b0;
        end else begin
            pc       <= fetch_pc + 32'd4;
            fd_valid <= 1'b1;
        end
    end

    decoder dec (
        .inst (inst_fd),
        .ctrl (ctrl_fd),
        .imm  (imm_fd)
    );

    reg_file rf (
        .clk (clk),
        .we  (rf_we),
        .ra1 (inst_fd.r.rs1),
        .ra2 (inst_fd.r.rs2),
        .wa  (w.rd),
        .wd  (wb_data),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // A redirect kills the wrong-path instruction in fetch/decode
    always_ff @(posedge clk) begin
        if (rst || redirect || !fd_valid) begin
            xm.ctrl <= '0;
        end else begin
            xm.ctrl <= ctrl_fd;
        end
        xm.pc      <= pc_fd;
        xm.imm     <= imm_fd;
        xm.rs1_val <= rd1;
        xm.rs2_val <= rd2;
        xm.rs1     <= inst_fd.r.rs1;
        xm.rs2     <= inst_fd.r.rs2;
        xm.rd      <= inst_fd.r.rd;
        xm.funct3  <= inst_fd.r.funct3;
    end

    assign fwd_a = w.ctrl.reg_we && w.rd != 5'd0 && w.rd == xm.rs1;
    assign fwd_b = w.ctrl.reg_we && w.rd != 5'd0 && w.rd == xm.rs2;
    assign op_a  = fwd_a ? wb_data : xm.rs1_val;
    assign op_b  = fwd_b ? wb_data : xm.rs2_val;
    assign alu_a = xm.ctrl.a_pc ? xm.pc : op_a;
    assign alu_b = xm.ctrl.b_imm ? xm.imm : op_b;

    alu alu_inst (
        .a      (alu_a),
        .b      (alu_b),
        .op     (xm.ctrl.alu_op),
        .funct3 (xm.funct3),
        .result (alu_result),
        .taken  (taken)
    );

    assign redirect = xm.ctrl.is_jal || xm.ctrl.is_jalr || (xm.ctrl.is_branch && taken);
    assign target   = xm.ctrl.is_jalr ? {alu_result[31:1], 1'b0} : xm.pc + xm.imm;

    lsu #(
        .DMEM_WORDS (DMEM_WORDS),
        .HOST_ADDR  (HOST_ADDR)
    ) lsu_inst (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (xm.ctrl),
        .addr       (alu_result),
        .store_data (op_b),
        .load_data  (load_data),
        .host       (host)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            w.ctrl <= '0;
        end else begin
            w.ctrl <= xm.ctrl;
        end
        w.rd  <= xm.rd;
        w.alu <= alu_result;
        w.pc  <= xm.pc;
    end

    always_comb begin
        case (w.ctrl.wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_PC4:  wb_data = w.pc + 32'd4;
            default: wb_data = w.alu;
        endcase
    end

    assign rf_we = w.ctrl.reg_we && w.rd != 5'd0;

endmodule

`default_nettype wire

/* design/cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2
    } wb_sel_e;

    // Access size, same coding as funct3[1:0] of loads and stores
    localparam logic [1:0] MEM_B = 2'd0;
    localparam logic [1:0] MEM_H = 2'd1;
    localparam logic [1:0] MEM_W = 2'd2;

    // All zero is a NOP
    typedef struct packed {
        logic       a_pc;
        logic       b_imm;
        alu_op_e    alu_op;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       mem_rd;
        logic       mem_wr;
        logic [1:0] mem_size;
        logic       mem_unsigned;
        logic       reg_we;
        wb_sel_e    wb_sel;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
    } xm_stage_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [4:0]  rd;
        logic [31:0] alu;
        logic [31:0] pc;
    } w_stage_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } host_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } imem_load_t;

endpackage

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_isa_pkg::*, cpu_pipe_pkg::*; (
    input  wire inst_u inst,
    output ctrl_t       ctrl,
    output logic [31:0] imm
);

    alu_op_e     arith_op;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    // Shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        unique case (inst.r.funct3)
            F3_ADD_SUB: arith_op = (inst.r.opcode == OPC_OP && inst.r.funct7[F7_ALT_BIT]) ?
                                   ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = inst.r.funct7[F7_ALT_BIT] ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.r.opcode)
            OPC_LUI: begin
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = ALU_PASS_B;
                ctrl.reg_we = 1'b1;
                imm         = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.a_pc   = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.reg_we = 1'b1;
                imm         = imm_u;
            end
            OPC_JAL: begin
                ctrl.is_jal = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = WB_PC4;
                imm         = imm_j;
            end
            OPC_JALR: begin
                ctrl.b_imm   = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                imm          = imm_i;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
            end
            OPC_LOAD: begin
                ctrl.b_imm        = 1'b1;
                ctrl.mem_rd       = 1'b1;
                ctrl.mem_size     = inst.i.funct3[1:0];
                ctrl.mem_unsigned = inst.i.funct3[2];
                ctrl.reg_we       = 1'b1;
                ctrl.wb_sel       = WB_LOAD;
                imm               = imm_i;
            end
            OPC_STORE: begin
                ctrl.b_imm    = 1'b1;
                ctrl.mem_wr   = 1'b1;
                ctrl.mem_size = inst.s.funct3[1:0];
                imm           = imm_s;
            end
            OPC_OP_IMM: begin
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = arith_op;
                ctrl.reg_we = 1'b1;
                imm         = imm_i;
            end
            OPC_OP: begin
                ctrl.alu_op = arith_op;
                ctrl.reg_we = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu import cpu_pipe_pkg::*; #(
    parameter int          DMEM_WORDS = 256,
    parameter logic [31:0] HOST_ADDR  = 32'h8000_0000
) (
    input  wire         clk,
    input  wire         rst,
    input  wire ctrl_t  ctrl,
    input  wire [31:0]  addr,
    input  wire [31:0]  store_data,
    output logic [31:0] load_data,
    output host_t       host
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   mem [DMEM_WORDS];
    logic [AW-1:0] word_idx;
    logic          host_hit;
    logic [3:0]    be;
    logic [3:0]    byte_we;
    logic [31:0]   wdata;
    logic [31:0]   rdata;
    logic [1:0]    ld_size;
    logic          ld_unsigned;
    logic [1:0]    ld_off;
    logic [31:0]   shifted;

    assign word_idx = addr[AW+1:2];
    assign host_hit = ctrl.mem_wr && ctrl.mem_size == MEM_W && addr == HOST_ADDR;
    assign wdata    = store_data << {addr[1:0], 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            MEM_B:   be = 4'b0001 << addr[1:0];
            MEM_H:   be = 4'b0011 << addr[1:0];
            default: be = 4'b1111;
        endcase
    end

    // The host word never lands in memory
    assign byte_we = (ctrl.mem_wr && !host_hit) ? be : 4'b0000;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_we[i]) begin
                mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        if (ctrl.mem_rd) begin
            rdata <= mem[word_idx];
        end
        ld_size     <= ctrl.mem_size;
        ld_unsigned <= ctrl.mem_unsigned;
        ld_off      <= addr[1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host.valid <= 1'b0;
        end else begin
            host.valid <= host_hit;
        end
        if (host_hit) begin
            host.data <= store_data;
        end
    end

    // Load extraction in writeback
    assign shifted = rdata >> {ld_off, 3'b000};

    always_comb begin
        case (ld_size)
            MEM_B:   load_data = {{24{!ld_unsigned && shifted[7]}}, shifted[7:0]};
            MEM_H:   load_data = {{16{!ld_unsigned && shifted[15]}}, shifted[15:0]};
            default: load_data = rdata;
        endcase
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire        clk,
    input  wire        we,
    input  wire [4:0]  ra1,
    input  wire [4:0]  ra2,
    input  wire [4:0]  wa,
    input  wire [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31];

    // x0 reads zero, a register written this cycle reads the new value
    function automatic logic [31:0] read_port(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return 32'd0;
        end
        if (we && wa == ra) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SR      = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    // Load and store funct3
    localparam logic [2:0] F3_LB  = 3'd0;
    localparam logic [2:0] F3_LH  = 3'd1;
    localparam logic [2:0] F3_LW  = 3'd2;
    localparam logic [2:0] F3_LBU = 3'd4;
    localparam logic [2:0] F3_LHU = 3'd5;
    localparam logic [2:0] F3_SB  = 3'd0;
    localparam logic [2:0] F3_SH  = 3'd1;
    localparam logic [2:0] F3_SW  = 3'd2;

    // Bit of funct7 that turns ADD into SUB and SRL into SRA
    localparam int F7_ALT_BIT = 5;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

`default_nettype wire

/* flist.f */
design/rv_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/decoder.sv
design/alu.sv
design/reg_file.sv
design/lsu.sv
design/cpu.sv
tb/clock_gen.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/Vcpu_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0

/* tb/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    input  wire  hold,
    output logic clk,
    output logic rst
);

    int count;

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        count = 0;
    end

    always #(HALF_PERIOD) clk = ~clk;

    // Reset stays high while held, then for a few more cycles
    always @(posedge clk) begin
        if (hold) begin
            count <= 0;
        end else if (count < RESET_CYCLES) begin
            count <= count + 1;
        end
    end

    always @(negedge clk) begin
        rst <= count < RESET_CYCLES;
    end

endmodule

`default_nettype wire

/* tb/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties #(
    parameter logic [31:0] HOST_ADDR = 32'h8000_0000
) (
    input wire        clk,
    input wire        rst,
    input wire        host_valid,
    input wire [31:0] fetch_pc,
    input wire        rf_we,
    input wire [4:0]  rf_wa,
    input wire        mem_wr,
    input wire [1:0]  mem_size,
    input wire [31:0] mem_addr,
    input wire [3:0]  byte_we
);

    host_quiet_in_reset: assert property (@(posedge clk) rst |=> !host_valid)
        else $error("host.valid high after a reset cycle");

    pc_aligned: assert property (@(posedge clk) disable iff (rst) fetch_pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned");

    no_x0_write: assert property (@(posedge clk) disable iff (rst) rf_we |-> rf_wa != 5'd0)
        else $error("register file write to x0");

    host_not_in_dmem: assert property (@(posedge clk) disable iff (rst)
        (mem_wr && mem_size == 2'd2 && mem_addr == HOST_ADDR) |-> byte_we == 4'b0000)
        else $error("host store wrote the data memory");

endmodule

`default_nettype wire

/* tb/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import rv_isa_pkg::*, cpu_pipe_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        hold;
    imem_load_t  imem_load;
    host_t       host;

    logic [31:0] prog[$];
    logic [31:0] expected[$];
    logic [31:0] lfsr;
    logic [7:0]  ref_bytes[8];
    int          limit;
    int          cycles;

    clock_gen clk_gen (
        .hold (hold),
        .clk  (clk),
        .rst  (rst)
    );

    cpu cpu_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_load (imem_load),
        .host      (host)
    );

    bind cpu cpu_properties #(.HOST_ADDR(HOST_ADDR)) props (
        .clk        (clk),
        .rst        (rst),
        .host_valid (host.valid),
        .fetch_pc   (fetch_pc),
        .rf_we      (rf_we),
        .rf_wa      (w.rd),
        .mem_wr     (xm.ctrl.mem_wr),
        .mem_size   (xm.ctrl.mem_size),
        .mem_addr   (alu_result),
        .byte_we    (lsu_inst.byte_we)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        inst_u x;
        x.r.funct7 = f7;
        x.r.rs2    = rs2;
        x.r.rs1    = rs1;
        x.r.funct3 = f3;
        x.r.rd     = rd;
        x.r.opcode = OPC_OP;
        return x;
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e opc, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        inst_u x;
        x.i.imm    = imm;
        x.i.rs1    = rs1;
        x.i.funct3 = f3;
        x.i.rd     = rd;
        x.i.opcode = opc;
        return x;
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        inst_u x;
        x.s.imm_hi = imm[11:5];
        x.s.rs2    = rs2;
        x.s.rs1    = rs1;
        x.s.funct3 = f3;
        x.s.imm_lo = imm[4:0];
        x.s.opcode = OPC_STORE;
        return x;
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        inst_u x;
        x.b.imm_12   = imm[12];
        x.b.imm_10_5 = imm[10:5];
        x.b.rs2      = rs2;
        x.b.rs1      = rs1;
        x.b.funct3   = f3;
        x.b.imm_4_1  = imm[4:1];
        x.b.imm_11   = imm[11];
        x.b.opcode   = OPC_BRANCH;
        return x;
    endfunction

    function automatic logic [31:0] enc_u(input opcode_e opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
        inst_u x;
        x.u.imm_31_12 = imm;
        x.u.rd        = rd;
        x.u.opcode    = opc;
        return x;
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        inst_u x;
        x.j.imm_20    = imm[20];
        x.j.imm_10_1  = imm[10:1];
        x.j.imm_11    = imm[11];
        x.j.imm_19_12 = imm[19:12];
        x.j.rd        = rd;
        x.j.opcode    = OPC_JAL;
        return x;
    endfunction

    // RV32I arithmetic, alt selects SUB and SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_bytes[off];
        h = {ref_bytes[(off + 1) % 8], ref_bytes[off]};
        case (f3)
            3'd0: return {{24{b[7]}}, b};
            3'd4: return {24'b0, b};
            3'd1: return {{16{h[15]}}, h};
            3'd5: return {16'b0, h};
            default: return {ref_bytes[off + 3], ref_bytes[off + 2], h};
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic host_store(input logic [4:0] rs, input logic [31:0] exp);
        emit(enc_s(F3_SW, rs, 5'd31, 12'd0));
        expected.push_back(exp);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(enc_u(OPC_LUI, upper[19:0], rd));
        emit(enc_i(OPC_OP_IMM, v[11:0], rd, F3_ADD_SUB, rd));
    endtask

    function automatic logic [31:0] nop();
        return enc_i(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD_SUB, 5'd0);
    endfunction

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [2:0]  br_f3[6];
        int          pc;
        load_reg(5'd31, 32'h8000_0000);
        // OP and OP-IMM with random operands
        repeat (2) begin
            rand_bits(32, a);
            rand_bits(32, b);
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (int k = 0; k < 10; k++) begin
                f3  = k < 8 ? 3'(k) : (k == 8 ? 3'd0 : 3'd5);
                alt = k >= 8;
                emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
                host_store(5'd3, alu_ref(f3, alt, a, b));
            end
            for (int k = 0; k < 9; k++) begin
                f3  = k < 8 ? 3'(k) : 3'd5;
                alt = k == 8;
                rand_bits(12, r);
                imm = r[11:0];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {alt ? 7'h20 : 7'h00, r[4:0]};
                end
                emit(enc_i(OPC_OP_IMM, imm, 5'd1, f3, 5'd3));
                host_store(5'd3, alu_ref(f3, alt, a, {{20{imm[11]}}, imm}));
            end
        end
        // Dependency distances 1 to 3
        for (int d = 1; d <= 3; d++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd4));
            repeat (d - 1) emit(nop());
            emit(enc_r(7'h00, 5'd4, 5'd4, F3_ADD_SUB, 5'd5));
            host_store(5'd5, (a + b) << 1);
        end
        // Stores and loads around 0x40
        rand_bits(32, w1);
        rand_bits(32, w2);
        rand_bits(32, w3);
        load_reg(5'd4, w1);
        load_reg(5'd6, w2);
        load_reg(5'd7, w3);
        emit(enc_i(OPC_OP_IMM, 12'h040, 5'd0, F3_ADD_SUB, 5'd5));
        emit(enc_s(F3_SW, 5'd4, 5'd5, 12'd0));
        emit(enc_s(F3_SW, 5'd6, 5'd5, 12'd4));
        emit(enc_s(F3_SB, 5'd7, 5'd5, 12'd1));
        emit(enc_s(F3_SH, 5'd7, 5'd5, 12'd6));
        for (int i = 0; i < 4; i++) begin
            ref_bytes[i]     = w1[8*i +: 8];
            ref_bytes[i + 4] = w2[8*i +: 8];
        end
        ref_bytes[1] = w3[7:0];
        ref_bytes[6] = w3[7:0];
        ref_bytes[7] = w3[15:8];
        for (int i = 0; i < 18; i++) begin
            int off;
            off = i < 8 ? i : (i < 16 ? 2 * (i % 4) : 4 * (i - 16));
            f3  = i < 8 ? (i[0] ? F3_LBU : F3_LB) :
                  (i < 16 ? (i < 12 ? F3_LH : F3_LHU) : F3_LW);
            emit(enc_i(OPC_LOAD, 12'(off), 5'd5, f3, 5'd8));
            host_store(5'd8, load_ref(f3, off));
        end
        // Branches, x9 marks whether the skipped slot ran
        rand_bits(32, a);
        rand_bits(32, b);
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                r1 = p == 1 ? 5'd2 : 5'd1;
                r2 = p == 0 ? 5'd2 : 5'd1;
                emit(enc_i(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD_SUB, 5'd9));
                emit(enc_b(br_f3[k], r1, r2, 13'd8));
                emit(enc_i(OPC_OP_IMM, 12'd1, 5'd9, F3_ADD_SUB, 5'd9));
                host_store(5'd9, branch_ref(br_f3[k], p == 1 ? b : a, p == 0 ? b : a) ?
                           32'd0 : 32'd1);
            end
        end
        emit(enc_i(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD_SUB, 5'd9));
        pc = prog.size() * 4;
        emit(enc_j(5'd10, 21'd8));
        emit(enc_i(OPC_OP_IMM, 12'd1, 5'd9, F3_ADD_SUB, 5'd9));
        host_store(5'd9, 32'd0);
        host_store(5'd10, 32'(pc + 4));
        pc = prog.size() * 4;
        emit(enc_u(OPC_AUIPC, 20'd0, 5'd11));
        emit(enc_i(OPC_JALR, 12'd12, 5'd11, 3'd0, 5'd12));
        emit(enc_i(OPC_OP_IMM, 12'd1, 5'd9, F3_ADD_SUB, 5'd9));
        host_store(5'd9, 32'd0);
        host_store(5'd12, 32'(pc + 8));
        // Park the core
        emit(enc_j(5'd0, 21'd0));
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %08h expected %08h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && host.valid) begin
            if (expected.size() == 0) begin
                $display("Host pulse arrived with no host store left in the program");
                $display("Errors found");
                $fatal(1);
            end else begin
                check("host.data", host.data, expected.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycles > limit) begin
                $display("Timeout: the program did not produce all host words in time");
                $display("Errors found");
                $fatal(1);
            end
        end
    end

    initial begin
        imem_load = '0;
        hold      = 1'b1;
        lfsr      = 32'h22fe;
        cycles    = 0;
        limit     = 1000000;
        build_program();
        limit = 10 * prog.size() + 50;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            imem_load.valid = 1'b1;
            imem_load.addr  = 32'(i);
            imem_load.data  = prog[i];
        end
        @(negedge clk);
        imem_load = '0;
        hold      = 1'b0;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // Quiet period catches extra host pulses
        repeat (20) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
